/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_lsu.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module tb_lsu;

    logic                   clk;
    logic                   rst;
    logic                   mem_valid;
    lsu_pkg::mem_op_t       mem_op;
    logic [`LSU_AWIDTH-1:0] mem_addr;
    logic [`LSU_XLEN-1:0]   mem_wdata;
    logic                   mem_done;
    lsu_pkg::lsu_status_t   mem_status;
    logic [`LSU_XLEN-1:0]   mem_rdata;
    logic                   mem_busy;

    // Stimulus and expected results, one entry per access
    lsu_pkg::mem_op_t     tbl_op[$];
    logic [31:0]          tbl_addr[$];
    logic [31:0]          tbl_wdata[$];
    lsu_pkg::lsu_status_t tbl_status[$];
    logic [31:0]          tbl_rdata[$];

    // Byte-addressed reference memory
    logic [7:0]  model_mem [logic [31:0]];
    logic [31:0] rng_state;
    int          errors;
    bit          table_ready;

    lsu_top i_lsu_top (
        .clk        (clk),
        .rst        (rst),
        .mem_valid  (mem_valid),
        .mem_op     (mem_op),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_done   (mem_done),
        .mem_status (mem_status),
        .mem_rdata  (mem_rdata),
        .mem_busy   (mem_busy)
    );

    always #5 clk = ~clk;

    // **************************************************
    // Helpers
    // **************************************************
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int access_bytes(input lsu_pkg::mem_op_t op);
        case (op)
            lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: return 2;
            lsu_pkg::op_lw, lsu_pkg::op_sw: return 4;
            default: return 1;
        endcase
    endfunction

    function automatic bit is_store(input lsu_pkg::mem_op_t op);
        return (op == lsu_pkg::op_sb) || (op == lsu_pkg::op_sh) || (op == lsu_pkg::op_sw);
    endfunction

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_data(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input lsu_pkg::lsu_status_t got,
                                input lsu_pkg::lsu_status_t exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
            abort_run();
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
            abort_run();
        end
    endtask

    // Expected status and load data follow the alignment, range and extension rules
    task automatic add_entry(input lsu_pkg::mem_op_t op, input logic [31:0] addr,
                             input logic [31:0] force_bits);
        int                   nbytes;
        logic [31:0]          wdata;
        logic [31:0]          rdata;
        lsu_pkg::lsu_status_t status;
        nbytes = access_bytes(op);
        wdata  = 32'h0;
        rdata  = 32'h0;
        if (is_store(op)) begin
            rng_state = xorshift32(rng_state);
            wdata     = rng_state | force_bits;
        end
        if ((addr % nbytes) != 0) begin
            status = lsu_pkg::stat_misaligned;
        end else if ((addr >> 2) >= `LSU_MEM_WORDS) begin
            status = lsu_pkg::stat_bus_err;
        end else begin
            status = lsu_pkg::stat_ok;
            for (int i = 0; i < nbytes; i++) begin
                if (is_store(op)) begin
                    model_mem[addr + 32'(i)] = wdata[i*8 +: 8];
                end else begin
                    rdata[i*8 +: 8] = model_mem[addr + 32'(i)];
                end
            end
            if (op == lsu_pkg::op_lb && rdata[7]) begin
                rdata[31:8] = '1;
            end
            if (op == lsu_pkg::op_lh && rdata[15]) begin
                rdata[31:16] = '1;
            end
        end
        tbl_op.push_back(op);
        tbl_addr.push_back(addr);
        tbl_wdata.push_back(wdata);
        tbl_status.push_back(status);
        tbl_rdata.push_back(rdata);
    endtask

    task automatic build_table();
        // Word round trip
        add_entry(lsu_pkg::op_sw, 32'h00, 32'h0);
        add_entry(lsu_pkg::op_lw, 32'h00, 32'h0);
        // Byte lanes over a known word
        add_entry(lsu_pkg::op_sw, 32'h04, 32'h0);
        add_entry(lsu_pkg::op_sb, 32'h04, 32'h0);
        add_entry(lsu_pkg::op_lw, 32'h04, 32'h0);
        add_entry(lsu_pkg::op_sb, 32'h05, 32'h0);
        add_entry(lsu_pkg::op_lw, 32'h04, 32'h0);
        add_entry(lsu_pkg::op_sb, 32'h06, 32'h80);
        add_entry(lsu_pkg::op_lw, 32'h04, 32'h0);
        add_entry(lsu_pkg::op_sb, 32'h07, 32'h0);
        add_entry(lsu_pkg::op_lw, 32'h04, 32'h0);
        add_entry(lsu_pkg::op_lb, 32'h06, 32'h0);
        add_entry(lsu_pkg::op_lbu, 32'h06, 32'h0);
        // Halfwords with the top bit set
        add_entry(lsu_pkg::op_sw, 32'h08, 32'h0);
        add_entry(lsu_pkg::op_sh, 32'h08, 32'h8000);
        add_entry(lsu_pkg::op_lw, 32'h08, 32'h0);
        add_entry(lsu_pkg::op_lh, 32'h08, 32'h0);
        add_entry(lsu_pkg::op_lhu, 32'h08, 32'h0);
        add_entry(lsu_pkg::op_sh, 32'h0A, 32'h8000);
        add_entry(lsu_pkg::op_lw, 32'h08, 32'h0);
        add_entry(lsu_pkg::op_lh, 32'h0A, 32'h0);
        add_entry(lsu_pkg::op_lhu, 32'h0A, 32'h0);
        // Misaligned accesses leave memory alone
        add_entry(lsu_pkg::op_sw, 32'h10, 32'h0);
        add_entry(lsu_pkg::op_lh, 32'h11, 32'h0);
        add_entry(lsu_pkg::op_sw, 32'h12, 32'h0);
        add_entry(lsu_pkg::op_sh, 32'h13, 32'h0);
        add_entry(lsu_pkg::op_lw, 32'h10, 32'h0);
        // Beyond the memory
        add_entry(lsu_pkg::op_sw, 32'h400, 32'h0);
        add_entry(lsu_pkg::op_lw, 32'h400, 32'h0);
        add_entry(lsu_pkg::op_lb, 32'h1001, 32'h0);
        add_entry(lsu_pkg::op_lw, 32'h00, 32'h0);
    endtask

    // Valid stays high after done when hold is set
    task automatic run_entry(input int idx, input bit hold);
        int cycles;
        int exp_cycles;
        exp_cycles = (tbl_status[idx] == lsu_pkg::stat_misaligned) ? 1 : `LSU_BUS_LATENCY;
        @(posedge clk);
        mem_op    <= tbl_op[idx];
        mem_addr  <= tbl_addr[idx];
        mem_wdata <= tbl_wdata[idx];
        mem_valid <= 1'b1;
        @(negedge clk);
        cycles = 0;
        while (mem_done !== 1'b1) begin
            @(negedge clk);
            cycles++;
        end
        check_status($sformatf("mem_status[%0d]", idx), mem_status, tbl_status[idx]);
        check_data($sformatf("mem_rdata[%0d]", idx), mem_rdata, tbl_rdata[idx]);
        check_cycles($sformatf("done latency[%0d]", idx), cycles, exp_cycles);
        // Access still in progress in its done cycle
        check_flag($sformatf("mem_busy[%0d]", idx), mem_busy, 1'b1);
        if (hold) begin
            repeat (`LSU_BUS_LATENCY + 2) begin
                @(negedge clk);
                check_flag("mem_done with valid held", mem_done, 1'b0);
                check_flag("mem_busy with valid held", mem_busy, 1'b0);
            end
        end
        @(posedge clk);
        mem_valid <= 1'b0;
    endtask

    // **************************************************
    // Main sequence and watchdog
    // **************************************************
    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        mem_valid = 1'b0;
        mem_op    = lsu_pkg::op_none;
        mem_addr  = '0;
        mem_wdata = '0;
        errors    = 0;
        rng_state = 32'd64;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("mem_done", mem_done, 1'b0);
        check_flag("mem_busy", mem_busy, 1'b0);
        for (int i = 0; i < tbl_op.size(); i++) begin
            run_entry(i, i == tbl_op.size() - 1);
        end
        @(posedge clk);
        if (errors == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run();
        end
    end

    initial begin
        wait (table_ready);
        repeat (tbl_op.size() * (`LSU_BUS_LATENCY + 4) + 100) @(posedge clk);
        $display("Timeout: mem_done never came");
        abort_run();
    end

endmodule

/* design/bus_sram.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module bus_sram (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   bus_wr_req,
    input  logic                   bus_rd_req,
    input  logic [`LSU_AWIDTH-1:0] bus_addr,
    input  logic [`LSU_XLEN-1:0]   bus_wdata,
    input  logic [3:0]             bus_wmask,
    output logic [`LSU_XLEN-1:0]   bus_rdata,
    output logic [1:0]             bus_resp,
    output logic                   bus_complete
);

    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
    localparam int CNT_W = $clog2(`LSU_BUS_LATENCY + 1);

    logic [`LSU_XLEN-1:0] mem [0:`LSU_MEM_WORDS-1];

    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic             rd_q;
    logic             err_q;
    logic [IDX_W-1:0] idx_q;

    logic             accept;
    logic             in_range;
    logic [IDX_W-1:0] idx;

    assign accept   = (bus_wr_req | bus_rd_req) & ~busy_q;
    assign in_range = (bus_addr[`LSU_AWIDTH-1:2] < `LSU_MEM_WORDS);
    assign idx      = bus_addr[IDX_W+1:2];

    // **************************************************
    // Latency counter
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(`LSU_BUS_LATENCY - 1);
        end else if (busy_q) begin
            if (cnt_q == '0) begin
                busy_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // Request details kept until completion
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_q  <= bus_rd_req;
            err_q <= ~in_range;
            idx_q <= idx;
        end
    end

    // Byte-lane write, dropped when out of range
    always_ff @(posedge clk) begin
        if (accept && bus_wr_req && in_range) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus_wmask[lane]) begin
                    mem[idx][lane*8 +: 8] <= bus_wdata[lane*8 +: 8];
                end
            end
        end
    end

    assign bus_complete = busy_q & (cnt_q == '0);

    always_comb begin
        bus_rdata = '0;
        bus_resp  = `LSU_RESP_OKAY;
        if (bus_complete) begin
            if (err_q) begin
                bus_resp = `LSU_RESP_ERR;
            end else if (rd_q) begin
                bus_rdata = mem[idx_q];
            end
        end
    end

endmodule

/* design/load_extract.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module load_extract (
    input  lsu_pkg::mem_op_t     mem_op,
    input  logic [1:0]           addr_low,
    input  logic [`LSU_XLEN-1:0] bus_rdata,
    output logic [`LSU_XLEN-1:0] mem_rdata
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // **************************************************
    // Lane select
    // **************************************************
    always_comb begin
        case (addr_low)
            2'b00:   sel_byte = bus_rdata[7:0];
            2'b01:   sel_byte = bus_rdata[15:8];
            2'b10:   sel_byte = bus_rdata[23:16];
            default: sel_byte = bus_rdata[31:24];
        endcase
    end

    // Only even offsets reach here for halfwords
    assign sel_half = addr_low[1] ? bus_rdata[31:16] : bus_rdata[15:0];

    // **************************************************
    // Extension
    // **************************************************
    always_comb begin
        case (mem_op)
            lsu_pkg::op_lb: begin
                mem_rdata = {{24{sel_byte[7]}}, sel_byte};
            end
            lsu_pkg::op_lbu: begin
                mem_rdata = {24'h000000, sel_byte};
            end
            lsu_pkg::op_lh: begin
                mem_rdata = {{16{sel_half[15]}}, sel_half};
            end
            lsu_pkg::op_lhu: begin
                mem_rdata = {16'h0000, sel_half};
            end
            lsu_pkg::op_lw: begin
                mem_rdata = bus_rdata;
            end
            default: begin
                mem_rdata = '0;
            end
        endcase
    end

endmodule

/* design/lsu_ctrl.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mem_valid,
    input  lsu_pkg::mem_op_t     mem_op,
    input  logic [1:0]           addr_low,
    input  logic                 bus_complete,
    input  logic [1:0]           bus_resp,
    output logic                 bus_wr_req,
    output logic                 bus_rd_req,
    output logic                 mem_done,
    output lsu_pkg::lsu_status_t mem_status,
    output logic                 mem_busy
);

    lsu_pkg::lsu_state_t state_q;
    lsu_pkg::lsu_state_t state_d;

    logic valid_q;
    logic start;
    logic is_load;
    logic is_store;
    logic size_half;
    logic size_word;
    logic misaligned;

    // **************************************************
    // Opcode decode
    // **************************************************
    always_comb begin
        is_load   = 1'b0;
        is_store  = 1'b0;
        size_half = 1'b0;
        size_word = 1'b0;
        case (mem_op)
            lsu_pkg::op_lb,
            lsu_pkg::op_lbu: is_load = 1'b1;
            lsu_pkg::op_lh,
            lsu_pkg::op_lhu: begin
                is_load   = 1'b1;
                size_half = 1'b1;
            end
            lsu_pkg::op_lw: begin
                is_load   = 1'b1;
                size_word = 1'b1;
            end
            lsu_pkg::op_sb: is_store = 1'b1;
            lsu_pkg::op_sh: begin
                is_store  = 1'b1;
                size_half = 1'b1;
            end
            lsu_pkg::op_sw: begin
                is_store  = 1'b1;
                size_word = 1'b1;
            end
            default: ;
        endcase
    end

    assign misaligned = (size_half & addr_low[0]) | (size_word & (addr_low != 2'b00));

    // Rising edge of valid, only honoured when idle
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mem_valid;
        end
    end

    assign start = mem_valid & ~valid_q & (state_q == lsu_pkg::st_idle) & (is_load | is_store);

    // Request pulses leave in the edge cycle itself
    assign bus_rd_req = start & is_load & ~misaligned;
    assign bus_wr_req = start & is_store & ~misaligned;

    // **************************************************
    // State machine
    // **************************************************
    always_comb begin
        state_d = state_q;
        case (state_q)
            lsu_pkg::st_idle: begin
                if (start) begin
                    state_d = misaligned ? lsu_pkg::st_fault : lsu_pkg::st_wait;
                end
            end
            lsu_pkg::st_wait: begin
                if (bus_complete) begin
                    state_d = lsu_pkg::st_idle;
                end
            end
            lsu_pkg::st_fault: state_d = lsu_pkg::st_idle;
            default: state_d = lsu_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= lsu_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign mem_done = (state_q == lsu_pkg::st_fault) |
                      ((state_q == lsu_pkg::st_wait) & bus_complete);

    always_comb begin
        if (state_q == lsu_pkg::st_fault) begin
            mem_status = lsu_pkg::stat_misaligned;
        end else if (bus_resp != `LSU_RESP_OKAY) begin
            mem_status = lsu_pkg::stat_bus_err;
        end else begin
            mem_status = lsu_pkg::stat_ok;
        end
    end

    assign mem_busy = (state_q != lsu_pkg::st_idle);

endmodule

/* design/lsu_pkg.sv */
package lsu_pkg;

    // Load/store opcodes seen on the core side
    typedef enum logic [3:0] {
        op_none,
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw
    } mem_op_t;

    // Controller states
    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_fault
    } lsu_state_t;

    // Result reported with every completed access
    typedef enum logic [1:0] {
        stat_ok,
        stat_misaligned,
        stat_bus_err
    } lsu_status_t;

endpackage

/* design/lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_valid,
    input  lsu_pkg::mem_op_t       mem_op,
    input  logic [`LSU_AWIDTH-1:0] mem_addr,
    input  logic [`LSU_XLEN-1:0]   mem_wdata,
    output logic                   mem_done,
    output lsu_pkg::lsu_status_t   mem_status,
    output logic [`LSU_XLEN-1:0]   mem_rdata,
    output logic                   mem_busy
);

    // Internal simple bus
    logic                   bus_wr_req;
    logic                   bus_rd_req;
    logic [`LSU_AWIDTH-1:0] bus_addr;
    logic [`LSU_XLEN-1:0]   bus_wdata;
    logic [3:0]             bus_wmask;
    logic [`LSU_XLEN-1:0]   bus_rdata;
    logic [1:0]             bus_resp;
    logic                   bus_complete;

    lsu_ctrl i_lsu_ctrl (
        .clk          (clk),
        .rst          (rst),
        .mem_valid    (mem_valid),
        .mem_op       (mem_op),
        .addr_low     (mem_addr[1:0]),
        .bus_complete (bus_complete),
        .bus_resp     (bus_resp),
        .bus_wr_req   (bus_wr_req),
        .bus_rd_req   (bus_rd_req),
        .mem_done     (mem_done),
        .mem_status   (mem_status),
        .mem_busy     (mem_busy)
    );

    // This slave works from the byte mask, so the size code stays open
    store_align i_store_align (
        .mem_op    (mem_op),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_wmask (bus_wmask),
        .bus_size  ()
    );

    load_extract i_load_extract (
        .mem_op    (mem_op),
        .addr_low  (mem_addr[1:0]),
        .bus_rdata (bus_rdata),
        .mem_rdata (mem_rdata)
    );

    bus_sram i_bus_sram (
        .clk          (clk),
        .rst          (rst),
        .bus_wr_req   (bus_wr_req),
        .bus_rd_req   (bus_rd_req),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_wmask    (bus_wmask),
        .bus_rdata    (bus_rdata),
        .bus_resp     (bus_resp),
        .bus_complete (bus_complete)
    );

endmodule

/* design/store_align.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module store_align (
    input  lsu_pkg::mem_op_t         mem_op,
    input  logic [`LSU_AWIDTH-1:0]   mem_addr,
    input  logic [`LSU_XLEN-1:0]     mem_wdata,
    output logic [`LSU_AWIDTH-1:0]   bus_addr,
    output logic [`LSU_XLEN-1:0]     bus_wdata,
    output logic [3:0]               bus_wmask,
    output logic [2:0]               bus_size
);

    logic [`LSU_XLEN-1:0] shifted;

    // Bus works on whole words, lanes come from the mask
    assign bus_addr = {mem_addr[`LSU_AWIDTH-1:2], 2'b00};

    assign shifted = mem_wdata << {mem_addr[1:0], 3'b000};

    always_comb begin
        bus_wdata = '0;
        bus_wmask = 4'b0000;
        bus_size  = 3'b111;
        case (mem_op)
            lsu_pkg::op_lb,
            lsu_pkg::op_lbu: bus_size = 3'b000;
            lsu_pkg::op_lh,
            lsu_pkg::op_lhu: bus_size = 3'b001;
            lsu_pkg::op_lw:  bus_size = 3'b010;
            lsu_pkg::op_sb: begin
                bus_wdata = shifted;
                bus_wmask = 4'b0001 << mem_addr[1:0];
                bus_size  = 3'b000;
            end
            lsu_pkg::op_sh: begin
                bus_wdata = shifted;
                bus_wmask = 4'b0011 << mem_addr[1:0];
                bus_size  = 3'b001;
            end
            lsu_pkg::op_sw: begin
                bus_wdata = shifted;
                bus_wmask = 4'b1111;
                bus_size  = 3'b010;
            end
            default: ;
        endcase
    end

endmodule

/* include/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Data and address widths
`define LSU_XLEN        32
`define LSU_AWIDTH      32

// Memory depth in 32-bit words
// Word addresses at or above this get an error response
`define LSU_MEM_WORDS   256

// Cycles from a bus request to its complete pulse, at least 1
`define LSU_BUS_LATENCY 2

// Bus response codes
`define LSU_RESP_OKAY   2'b00
`define LSU_RESP_ERR    2'b10

`endif

/* list.f */
+incdir+include
design/lsu_pkg.sv
design/lsu_ctrl.sv
design/store_align.sv
design/load_extract.sv
design/bus_sram.sv
design/lsu_top.sv
bench/tb_lsu.sv
